// ==== Bender.yml ====
package:
  name: mem_sys

sources:
  # Packages first, then the RTL bottom up.
  - verilog/wb_pkg.sv
  - verilog/sram_pkg.sv
  - verilog/mem_port.sv
  - verilog/sram_wb.sv
  - verilog/mem_sys.sv
  - target: simulation
    files:
      - sim/sram_model.sv
      - sim/tb_mem_sys.sv

// ==== mem_sys.f ====
verilog/wb_pkg.sv
verilog/sram_pkg.sv
verilog/mem_port.sv
verilog/sram_wb.sv
verilog/mem_sys.sv
sim/sram_model.sv
sim/tb_mem_sys.sv

// ==== sim/sram_model.sv ====
`timescale 1ns/1ps

module sram_model
    import sram_pkg::*;
(
    input  sram_pins_t                 i_sram,
    input  logic [SRAM_DATA_WIDTH-1:0] i_dq,
    output logic [SRAM_DATA_WIDTH-1:0] o_dq
);

    localparam int DEPTH = 1 << SRAM_ADDR_WIDTH;

    logic [SRAM_DATA_WIDTH-1:0] mem [DEPTH];
    logic [SRAM_DATA_WIDTH-1:0] rd_word;
    logic                       rd_en;

    // Power-up contents, a function of the full half-word address.
    function automatic logic [SRAM_DATA_WIDTH-1:0] fill_value(
        input logic [SRAM_ADDR_WIDTH-1:0] a
    );
        return a[15:0] ^ {4{a[19:16]}};
    endfunction

    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = fill_value(SRAM_ADDR_WIDTH'(a));
        end
    end

    assign rd_en   = !i_sram.ce_n && !i_sram.oe_n;
    assign rd_word = mem[i_sram.addr];

    assign o_dq[15:8] = (rd_en && !i_sram.ub_n) ? rd_word[15:8] : 8'hzz;
    assign o_dq[7:0]  = (rd_en && !i_sram.lb_n) ? rd_word[7:0]  : 8'hzz;

    // Write after the pins settle, so a change of address and data in one
    // step never lands the new data on the old address.
    always begin
        @(i_sram or i_dq);
        #0.5;
        if (!i_sram.ce_n && !i_sram.we_n) begin
            if (!i_sram.ub_n) begin
                mem[i_sram.addr][15:8] = i_dq[15:8];
            end
            if (!i_sram.lb_n) begin
                mem[i_sram.addr][7:0] = i_dq[7:0];
            end
        end
    end

endmodule

// ==== sim/tb_mem_sys.sv ====
`timescale 1ns/1ps

module tb_mem_sys
    import wb_pkg::*, sram_pkg::*;
();

    localparam int          CLK_HALF    = 2;
    localparam int          RST_CYCLES  = 16;
    localparam int          IDLE_CYCLES = 20;
    localparam int          TIMEOUT     = 50;
    localparam int          HOLD_CYCLES = 10;
    localparam int          N_RANDOM    = 64;
    localparam logic [31:0] RAND_BASE   = 32'h0001_0000;
    localparam int          RAND_BYTES  = 256;

    typedef struct packed {
        mem_cmd_t    cmd;
        logic [31:0] exp;
    } vec_t;

    logic                       clk;
    logic                       rst_n;
    logic                       req;
    mem_cmd_t                   cmd;
    logic                       ack;
    logic [31:0]                rdata;
    sram_pins_t                 sram_pins;
    logic [SRAM_DATA_WIDTH-1:0] sram_dq_out;
    logic [SRAM_DATA_WIDTH-1:0] sram_dq_in;

    vec_t       vecs[$];
    string      vec_names[$];
    logic [7:0] mirror [RAND_BYTES];
    integer     seed = 32'h970284f6;

    mem_sys i_dut (
        .clk(clk),
        .i_rst_n(rst_n),
        .i_req(req),
        .i_cmd(cmd),
        .o_ack(ack),
        .o_rdata(rdata),
        .o_sram(sram_pins),
        .o_sram_dq(sram_dq_out),
        .i_sram_dq(sram_dq_in)
    );

    sram_model sram_inst (
        .i_sram(sram_pins),
        .i_dq(sram_dq_out),
        .o_dq(sram_dq_in)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %08h, actual %08h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1, "Value mismatch in %s.", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s did not happen within %0d cycles.", what, TIMEOUT);
        $display("SIMULATION FAILED");
        $fatal(1, "Handshake timeout.");
    endtask

    task automatic add_vec(input string name, input logic we, input mem_size_t size,
                           input logic sgn, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp);
        vec_t v;
        v.cmd.we        = we;
        v.cmd.size      = size;
        v.cmd.is_signed = sgn;
        v.cmd.addr      = addr;
        v.cmd.wdata     = wdata;
        v.exp           = exp;
        vecs.push_back(v);
        vec_names.push_back(name);
    endtask

    // Four-phase request that may hold req for a while after the ack.
    task automatic run_access(input mem_cmd_t c, input int hold, input string name,
                              output logic [31:0] data);
        int cnt;
        @(posedge clk);
        req <= 1'b1;
        cmd <= c;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT) begin
                timeout_fail({name, " ack rise"});
            end
        end while (!ack);
        data = rdata;
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            check_value({name, " ack held"}, 32'd1, ack);
        end
        req <= 1'b0;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT) begin
                timeout_fail({name, " ack fall"});
            end
        end while (ack);
    endtask

    task automatic build_table();
        add_vec("sw 0x0",        1, MEM_WORD, 0, 32'h0000_0000, 32'hCAFE_F00D, 32'h0);
        add_vec("sw 0x4",        1, MEM_WORD, 0, 32'h0000_0004, 32'h1234_5678, 32'h0);
        add_vec("sw top",        1, MEM_WORD, 0, 32'h001F_FFFC, 32'hA5A5_5A5A, 32'h0);
        add_vec("sw 0x12344",    1, MEM_WORD, 0, 32'h0001_2344, 32'h0F1E_2D3C, 32'h0);
        add_vec("lw 0x0",        0, MEM_WORD, 0, 32'h0000_0000, 32'h0, 32'hCAFE_F00D);
        add_vec("lw 0x4",        0, MEM_WORD, 0, 32'h0000_0004, 32'h0, 32'h1234_5678);
        add_vec("lw top",        0, MEM_WORD, 0, 32'h001F_FFFC, 32'h0, 32'hA5A5_5A5A);
        add_vec("lw 0x12344",    0, MEM_WORD, 0, 32'h0001_2344, 32'h0, 32'h0F1E_2D3C);
        // Lane merges on one word.
        add_vec("sw 0x100",      1, MEM_WORD, 0, 32'h0000_0100, 32'h1122_3344, 32'h0);
        add_vec("sb 0x102",      1, MEM_BYTE, 0, 32'h0000_0102, 32'h0000_00A5, 32'h0);
        add_vec("lw merge b",    0, MEM_WORD, 0, 32'h0000_0100, 32'h0, 32'h11A5_3344);
        add_vec("sh 0x100",      1, MEM_HALF, 0, 32'h0000_0100, 32'h1234_BEEF, 32'h0);
        add_vec("lw merge h",    0, MEM_WORD, 0, 32'h0000_0100, 32'h0, 32'h11A5_BEEF);
        // Extension of bytes and halves.
        add_vec("sw 0x200",      1, MEM_WORD, 0, 32'h0000_0200, 32'h80F7_7F85, 32'h0);
        add_vec("lb 0x200 s",    0, MEM_BYTE, 1, 32'h0000_0200, 32'h0, 32'hFFFF_FF85);
        add_vec("lb 0x200 u",    0, MEM_BYTE, 0, 32'h0000_0200, 32'h0, 32'h0000_0085);
        add_vec("lb 0x201 s",    0, MEM_BYTE, 1, 32'h0000_0201, 32'h0, 32'h0000_007F);
        add_vec("lb 0x202 u",    0, MEM_BYTE, 0, 32'h0000_0202, 32'h0, 32'h0000_00F7);
        add_vec("lb 0x203 s",    0, MEM_BYTE, 1, 32'h0000_0203, 32'h0, 32'hFFFF_FF80);
        add_vec("lh 0x200 s",    0, MEM_HALF, 1, 32'h0000_0200, 32'h0, 32'h0000_7F85);
        add_vec("lh 0x202 s",    0, MEM_HALF, 1, 32'h0000_0202, 32'h0, 32'hFFFF_80F7);
        add_vec("lh 0x202 u",    0, MEM_HALF, 0, 32'h0000_0202, 32'h0, 32'h0000_80F7);
        add_vec("lh 0x203 s",    0, MEM_HALF, 1, 32'h0000_0203, 32'h0, 32'hFFFF_80F7);
        add_vec("lw 0x203",      0, MEM_WORD, 0, 32'h0000_0203, 32'h0, 32'h80F7_7F85);
        // Outside the window; 0x200000 would alias word 0 if it reached the SRAM.
        add_vec("lw oow",        0, MEM_WORD, 0, 32'h0020_0000, 32'h0, 32'h0);
        add_vec("sw oow",        1, MEM_WORD, 0, 32'h0020_0000, 32'hDEAD_BEEF, 32'h0);
        add_vec("lw 0x0 after",  0, MEM_WORD, 0, 32'h0000_0000, 32'h0, 32'hCAFE_F00D);
        add_vec("lw oow high",   0, MEM_WORD, 0, 32'hFFFF_FFFC, 32'h0, 32'h0);
    endtask

    // Mirror of the random region starting from the SRAM power-up fill.
    task automatic init_mirror();
        logic [31:0] a;
        logic [19:0] h;
        logic [15:0] f;
        for (int i = 0; i < RAND_BYTES; i++) begin
            a         = RAND_BASE + i;
            h         = a[20:1];
            f         = h[15:0] ^ {4{h[19:16]}};
            mirror[i] = a[0] ? f[15:8] : f[7:0];
        end
    endtask

    function automatic logic [31:0] predict_load(input mem_size_t size, input logic sgn,
                                                 input int off);
        logic [7:0]  b;
        logic [15:0] h;
        b = mirror[off];
        h = {mirror[off+1], mirror[off]};
        case (size)
            MEM_BYTE: return {{24{sgn & b[7]}}, b};
            MEM_HALF: return {{16{sgn & h[15]}}, h};
            default:  return {mirror[off+3], mirror[off+2], h};
        endcase
    endfunction

    task automatic store_mirror(input mem_size_t size, input int off, input logic [31:0] wd);
        mirror[off] = wd[7:0];
        if (size != MEM_BYTE) begin
            mirror[off+1] = wd[15:8];
        end
        if (size == MEM_WORD) begin
            mirror[off+2] = wd[23:16];
            mirror[off+3] = wd[31:24];
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] r;
        logic [31:0] wd;
        logic [31:0] exp;
        mem_cmd_t    c;
        mem_size_t   sz;
        int          off;
        string       name;

        clk   = 1'b0;
        rst_n = 1'b0;
        req   = 1'b0;
        cmd   = '0;
        build_table();
        init_mirror();
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(posedge clk);
            check_value("idle ack", 32'd0, ack);
            check_value("idle strobes", 32'h1F, {sram_pins.ce_n, sram_pins.oe_n,
                                                 sram_pins.we_n, sram_pins.ub_n, sram_pins.lb_n});
        end

        foreach (vecs[i]) begin
            run_access(vecs[i].cmd, 0, vec_names[i], data);
            if (!vecs[i].cmd.we) begin
                check_value(vec_names[i], vecs[i].exp, data);
            end
        end

        c           = '0;
        c.size      = MEM_WORD;
        c.addr      = 32'h0000_0200;
        run_access(c, HOLD_CYCLES, "ack hold", data);
        check_value("ack hold data", 32'h80F7_7F85, data);
        @(posedge clk);
        check_value("ack low after drop", 32'd0, ack);

        for (int n = 0; n < N_RANDOM; n++) begin
            r  = $random(seed);
            wd = $random(seed);
            sz = (r[2:1] == 2'd3) ? MEM_WORD : mem_size_t'(r[2:1]);
            off = int'(r[15:8]);
            if (sz == MEM_HALF) begin
                off = off & ~1;
            end else if (sz == MEM_WORD) begin
                off = off & ~3;
            end
            c.we        = r[0];
            c.size      = sz;
            c.is_signed = r[3];
            c.addr      = RAND_BASE + r[15:8];  // The port ignores the unaligned low bits.
            c.wdata     = wd;
            name        = $sformatf("random %0d", n);
            exp         = predict_load(sz, r[3], off);
            run_access(c, 0, name, data);
            if (r[0]) begin
                store_mirror(sz, off, wd);
            end else begin
                check_value(name, exp, data);
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== verilog/mem_port.sv ====
`timescale 1ns/1ps

module mem_port
    import wb_pkg::*;
(
    input  logic                     clk,
    input  logic                     i_rst_n,

    input  logic                     i_req,
    input  mem_cmd_t                 i_cmd,
    output logic                     o_ack,
    output logic [WB_DATA_WIDTH-1:0] o_rdata,

    output wb_m2s_t                  o_wb,
    input  wb_s2m_t                  i_wb
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_DONE
    } state_t;

    state_t                   state_q;
    state_t                   state_d;
    mem_cmd_t                 cmd_q;
    logic [WB_SEL_WIDTH-1:0]  sel;
    wb_word_u                 wdata;
    wb_word_u                 rword;
    logic [WB_BYTE_WIDTH-1:0] rbyte;
    logic [WB_HALF_WIDTH-1:0] rhalf;
    logic [WB_DATA_WIDTH-1:0] rdata_ext;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (i_req) begin
                    state_d = S_BUS;
                end
            end
            S_BUS: begin
                if (i_wb.ack) begin
                    state_d = S_DONE;
                end
            end
            S_DONE: begin
                if (!i_req) begin
                    state_d = S_IDLE;  // Requester has dropped its request.
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && i_req) begin
            cmd_q <= i_cmd;
        end
    end

    // Lane selects and store data placement.
    always_comb begin
        case (cmd_q.size)
            MEM_BYTE: begin
                sel        = WB_SEL_WIDTH'(1) << cmd_q.addr[WB_ADDR_LSB-1:0];
                wdata.word = {4{cmd_q.wdata[WB_BYTE_WIDTH-1:0]}};
            end
            MEM_HALF: begin
                sel        = cmd_q.addr[1] ? 4'b1100 : 4'b0011;
                wdata.word = {2{cmd_q.wdata[WB_HALF_WIDTH-1:0]}};
            end
            default: begin
                sel        = '1;
                wdata.word = cmd_q.wdata;
            end
        endcase
    end

    always_comb begin
        o_wb.cyc  = (state_q == S_BUS);
        o_wb.stb  = (state_q == S_BUS);
        o_wb.we   = cmd_q.we;
        o_wb.sel  = sel;
        o_wb.addr = {cmd_q.addr[WB_ADDR_WIDTH-1:WB_ADDR_LSB], WB_ADDR_LSB'(0)};  // Word aligned.
        o_wb.data = wdata.word;
    end

    // Load lane selection and extension.
    always_comb begin
        rword.word = i_wb.data;
        rbyte      = rword.bytes[cmd_q.addr[WB_ADDR_LSB-1:0]];
        rhalf      = cmd_q.addr[1] ? rword.half.hi : rword.half.lo;
        case (cmd_q.size)
            MEM_BYTE: begin
                rdata_ext = {{(WB_DATA_WIDTH - WB_BYTE_WIDTH){cmd_q.is_signed & rbyte[WB_BYTE_WIDTH-1]}},
                             rbyte};
            end
            MEM_HALF: begin
                rdata_ext = {{(WB_DATA_WIDTH - WB_HALF_WIDTH){cmd_q.is_signed & rhalf[WB_HALF_WIDTH-1]}},
                             rhalf};
            end
            default: rdata_ext = rword.word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state_q == S_BUS && i_wb.ack) begin
            o_rdata <= cmd_q.we ? '0 : rdata_ext;  // Stores return zero.
        end
    end

    assign o_ack = (state_q == S_DONE);

endmodule

// ==== verilog/mem_sys.sv ====
`timescale 1ns/1ps

module mem_sys
    import wb_pkg::*, sram_pkg::*;
(
    input  logic                       clk,
    input  logic                       i_rst_n,

    // Core load/store port.
    input  logic                       i_req,
    input  mem_cmd_t                   i_cmd,
    output logic                       o_ack,
    output logic [WB_DATA_WIDTH-1:0]   o_rdata,

    // SRAM pins.
    output sram_pins_t                 o_sram,
    output logic [SRAM_DATA_WIDTH-1:0] o_sram_dq,
    input  logic [SRAM_DATA_WIDTH-1:0] i_sram_dq
);

    wb_m2s_t wb_m2s;
    wb_s2m_t wb_s2m;

    mem_port mem_port_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_req(i_req),
        .i_cmd(i_cmd),
        .o_ack(o_ack),
        .o_rdata(o_rdata),
        .o_wb(wb_m2s),
        .i_wb(wb_s2m)
    );

    sram_wb sram_wb_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_wb(wb_m2s),
        .o_wb(wb_s2m),
        .o_sram(o_sram),
        .o_sram_dq(o_sram_dq),
        .i_sram_dq(i_sram_dq)
    );

endmodule

// ==== verilog/sram_pkg.sv ====
package sram_pkg;

    // External asynchronous SRAM, 16 bits wide, half-word addressed.
    localparam int SRAM_ADDR_WIDTH = 20;
    localparam int SRAM_DATA_WIDTH = 16;

    // Location and size of the SRAM window on the bus.
    localparam logic [31:0] SRAM_BASE_ADDR = 32'h0000_0000;
    localparam int unsigned SRAM_BYTES     = 1 << (SRAM_ADDR_WIDTH + 1);

    // Strobe hold time of each half access, in clock cycles.
    localparam int SRAM_ACCESS_CYCLES = 2;
    localparam int SRAM_CNT_WIDTH     = $clog2(SRAM_ACCESS_CYCLES + 1);

    // Control and address pins, all strobes active low.
    typedef struct packed {
        logic [SRAM_ADDR_WIDTH-1:0] addr;
        logic                       ce_n;
        logic                       oe_n;
        logic                       we_n;
        logic                       ub_n;  // Upper byte, dq[15:8].
        logic                       lb_n;  // Lower byte, dq[7:0].
    } sram_pins_t;

endpackage

// ==== verilog/sram_wb.sv ====
`timescale 1ns/1ps

module sram_wb
    import wb_pkg::*, sram_pkg::*;
(
    input  logic                       clk,
    input  logic                       i_rst_n,

    input  wb_m2s_t                    i_wb,
    output wb_s2m_t                    o_wb,

    output sram_pins_t                 o_sram,
    output logic [SRAM_DATA_WIDTH-1:0] o_sram_dq,
    input  logic [SRAM_DATA_WIDTH-1:0] i_sram_dq
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LO,
        S_HI,
        S_ACK
    } state_t;

    state_t                     state_q;
    state_t                     state_d;
    logic [SRAM_CNT_WIDTH-1:0]  cnt_q;
    logic                       last_cycle;
    logic                       req;
    logic [WB_ADDR_WIDTH-1:0]   offset;
    logic                       in_window;

    logic                       we_q;
    logic [WB_SEL_WIDTH-1:0]    sel_q;
    logic [SRAM_ADDR_WIDTH-2:0] word_q;
    wb_word_u                   wdata_q;
    wb_word_u                   rdata_q;

    logic                       hi_half;
    logic [1:0]                 lanes;
    logic                       active;

    assign req        = i_wb.cyc & i_wb.stb;
    assign offset     = i_wb.addr - SRAM_BASE_ADDR;
    assign in_window  = (offset < SRAM_BYTES);
    assign last_cycle = (cnt_q == SRAM_CNT_WIDTH'(SRAM_ACCESS_CYCLES - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req) begin
                    state_d = in_window ? S_LO : S_ACK;  // Outside the window, ack at once.
                end
            end
            S_LO: begin
                if (last_cycle) begin
                    state_d = S_HI;
                end
            end
            S_HI: begin
                if (last_cycle) begin
                    state_d = S_ACK;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if ((state_q == S_LO || state_q == S_HI) && !last_cycle) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    // Request capture and read data assembly.
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req) begin
            we_q         <= i_wb.we;
            sel_q        <= i_wb.sel;
            word_q       <= offset[SRAM_ADDR_WIDTH:WB_ADDR_LSB];
            wdata_q.word <= i_wb.data;
            if (!in_window) begin
                rdata_q.word <= '0;
            end
        end
        if (state_q == S_LO && last_cycle && !we_q) begin
            rdata_q.half.lo <= i_sram_dq;
        end
        if (state_q == S_HI && last_cycle && !we_q) begin
            rdata_q.half.hi <= i_sram_dq;
        end
    end

    // A half with no selected lane keeps every strobe high.
    assign hi_half = (state_q == S_HI);
    assign lanes   = hi_half ? sel_q[3:2] : sel_q[1:0];
    assign active  = (state_q == S_LO || state_q == S_HI) && (|lanes);

    always_comb begin
        o_sram.addr = {word_q, hi_half};  // Low half at 2N, high half at 2N+1.
        o_sram.ce_n = !active;
        o_sram.oe_n = !(active && !we_q);
        o_sram.we_n = !(active && we_q);
        o_sram.ub_n = !(active && lanes[1]);
        o_sram.lb_n = !(active && lanes[0]);
    end

    assign o_sram_dq = hi_half ? wdata_q.half.hi : wdata_q.half.lo;

    always_comb begin
        o_wb.ack  = (state_q == S_ACK);
        o_wb.data = rdata_q.word;
    end

endmodule

// ==== verilog/wb_pkg.sv ====
package wb_pkg;

    localparam int WB_ADDR_WIDTH = 32;
    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

    localparam int WB_BYTE_WIDTH = 8;
    localparam int WB_HALF_WIDTH = WB_DATA_WIDTH / 2;
    localparam int WB_ADDR_LSB   = $clog2(WB_SEL_WIDTH);  // Byte offset bits within a word.

    // Access size of a core load or store.
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    // One core request, held stable while the request is raised.
    typedef struct packed {
        logic                     we;
        mem_size_t                size;
        logic                     is_signed;
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [WB_DATA_WIDTH-1:0] wdata;
    } mem_cmd_t;

    // Classic cycle signals from master to slave.
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_SEL_WIDTH-1:0]  sel;
        logic [WB_ADDR_WIDTH-1:0] addr;
        logic [WB_DATA_WIDTH-1:0] data;
    } wb_m2s_t;

    // Slave response.
    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] data;
    } wb_s2m_t;

    typedef struct packed {
        logic [WB_HALF_WIDTH-1:0] hi;
        logic [WB_HALF_WIDTH-1:0] lo;
    } wb_halves_t;

    // One bus word seen whole, as two halves or as byte lanes.
    typedef union packed {
        logic [WB_DATA_WIDTH-1:0]                    word;
        wb_halves_t                                  half;
        logic [WB_SEL_WIDTH-1:0][WB_BYTE_WIDTH-1:0]  bytes;
    } wb_word_u;

endpackage
